/* compile.f */
+incdir+hdl
hdl/cvr_pkg.sv
hdl/cvr_cmd_decode.sv
hdl/cvr_bank_execute.sv
hdl/cvr_read_result.sv
hdl/cvr_top.sv
dv/cvr_assertions.sv
dv/cvr_tb.sv

/* dv/cvr_assertions.sv */
// ==========================================================================
// protocol and timing assertions for the register-ready table
// bound into cvr_top so they watch the outside ports directly
// ==========================================================================

`include "cvr_config.svh"

module cvr_assertions (
  input logic                   clka,
  input logic                   rst,
  input logic [`CVR_NWPORT-1:0] cmd_stb,
  input logic [`CVR_NRPORT-1:0] rd_stb,
  input logic [`CVR_NRPORT-1:0] rd_done,
  input logic                   busy,
  input logic                   copy_done
);
  timeunit 1ns;
  timeprecision 100ps;

  // the copy engine owns the banks so commands must stay away
  a_no_cmd_busy: assert property (@(posedge clka) disable iff (rst) busy |-> (cmd_stb == '0))
    else $error("command strobe high while busy");

  a_rd_latency: assert property (@(posedge clka) disable iff (rst) rd_done == $past(rd_stb))
    else $error("rd_done does not follow rd_stb by one cycle");

  // copy_done sits in the last busy cycle so busy must drop right after it
  a_done_busy: assert property (@(posedge clka) disable iff (rst)
    $past(copy_done) |-> ($past(busy) && !busy))
    else $error("copy_done outside the last busy cycle");

  // first cycle out of reset is quiet on every status output
  a_reset_quiet: assert property (@(posedge clka)
    $fell(rst) |-> (!busy && !copy_done && rd_done == '0))
    else $error("status outputs active right after reset");

endmodule

bind cvr_top cvr_assertions u_assertions (
  .clka      (clka),
  .rst       (rst),
  .cmd_stb   (cmd_stb),
  .rd_stb    (rd_stb),
  .rd_done   (rd_done),
  .busy      (busy),
  .copy_done (copy_done)
);

/* dv/cvr_tb.sv */
// ==========================================================================
// testbench for the checkpointed register-ready table
// drives both command ports and both read ports of cvr_top, keeps a
// reference model of every ready bit and checks each read against it
// ==========================================================================

`include "cvr_config.svh"

module cvr_tb
  import cvr_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int READ_TIMEOUT = 8;                 // cycles allowed for outstanding reads
  localparam int COPY_TIMEOUT = `CVR_NPREGS + 4;   // cycles allowed for busy to fall

  logic                           clka;
  logic                           rst;
  logic         [`CVR_NWPORT-1:0] cmd_stb;
  cvr_op_e      [`CVR_NWPORT-1:0] cmd_op;
  checkpt_ndx_t [`CVR_NWPORT-1:0] cmd_chk;
  pregno_t      [`CVR_NWPORT-1:0] cmd_preg;
  checkpt_ndx_t                   copy_src;
  logic         [`CVR_NRPORT-1:0] rd_stb;
  checkpt_ndx_t [`CVR_NRPORT-1:0] rd_chk;
  pregno_t      [`CVR_NRPORT-1:0] rd_preg;
  logic         [`CVR_NRPORT-1:0] rd_done;
  logic         [`CVR_NRPORT-1:0] rd_data;
  logic                           busy;
  logic                           copy_done;

  chk_word_t model [`CVR_NPREGS];  // expected ready word of every register
  logic      exp_q0 [$];           // expected bits of port 0 reads in flight
  logic      exp_q1 [$];
  int        mismatches = 0;
  int        other_errs = 0;
  int        reads_done = 0;

  cvr_top dut0 (
    .clka (clka), .rst (rst), .cmd_stb (cmd_stb), .cmd_op (cmd_op), .cmd_chk (cmd_chk),
    .cmd_preg (cmd_preg), .copy_src (copy_src), .rd_stb (rd_stb), .rd_chk (rd_chk),
    .rd_preg (rd_preg), .rd_done (rd_done), .rd_data (rd_data), .busy (busy),
    .copy_done (copy_done)
  );

  initial begin
    clka = 1'b0;
    forever #5 clka = ~clka;  // 10 ns period
  end

  // ==========================================================================
  // reference model and random helpers
  // ==========================================================================
  function automatic logic ref_ready(checkpt_ndx_t chk, pregno_t preg);
    return model[preg][chk];
  endfunction

  // applies whatever the command ports carry this cycle
  // port 1 goes last so it wins when both touch the same bit
  task automatic apply_model();
    if (cmd_stb[0] && cmd_op[0] == OP_COPY) begin
      for (int i = 0; i < `CVR_NPREGS; i++) begin
        model[i][cmd_chk[0]] = model[i][copy_src];  // port 1 is dropped in a copy cycle
      end
    end else begin
      for (int p = 0; p < `CVR_NWPORT; p++) begin
        if (cmd_stb[p] && (cmd_op[p] == OP_SET || cmd_op[p] == OP_CLR)) begin
          model[cmd_preg[p]][cmd_chk[p]] = (cmd_op[p] == OP_SET);
        end
      end
    end
  endtask

  function automatic checkpt_ndx_t rand_chk();
    return checkpt_ndx_t'($urandom_range(0, `CVR_NCHECK - 1));
  endfunction

  function automatic pregno_t rand_preg();
    return pregno_t'($urandom_range(0, `CVR_NPREGS - 1));
  endfunction

  // registers 0 to 15 only so random commands collide often
  function automatic pregno_t narrow_preg();
    return pregno_t'($urandom_range(0, 15));
  endfunction

  // any column except the one given
  function automatic checkpt_ndx_t other_chk(checkpt_ndx_t c);
    return checkpt_ndx_t'(int'(c) + 1 + int'($urandom_range(0, `CVR_NCHECK - 2)));
  endfunction

  function automatic pregno_t other_preg(pregno_t p);
    return pregno_t'(int'(p) + 1 + int'($urandom_range(0, `CVR_NPREGS - 2)));
  endfunction

  function automatic cvr_op_e rand_setclr();
    return ($urandom_range(0, 1) == 1) ? OP_SET : OP_CLR;
  endfunction

  function automatic cvr_op_e pick_op(bit allow_copy);
    int u;
    u = int'($urandom_range(0, allow_copy ? 3 : 2));
    case (u)
      0:       return OP_NOP;
      1:       return OP_SET;
      2:       return OP_CLR;
      default: return OP_COPY;  // only offered to port 1 where it must be ignored
    endcase
  endfunction

  // ==========================================================================
  // compare tasks
  // ==========================================================================
  task automatic check_ready(string name, logic got, logic exp);
    reads_done++;
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      mismatches++;
      $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic note_error(string what);
    other_errs++;
    $display("error at %0t: %s", $time, what);
  endtask

  // results are taken at the falling edge where rd_done and rd_data are settled
  always @(negedge clka) begin
    if (!rst && rd_done[0]) begin
      if (exp_q0.size() == 0) note_error("rd_done on port 0 with no read outstanding");
      else check_ready("rd_data[0]", rd_data[0], exp_q0.pop_front());
    end
    if (!rst && rd_done[1]) begin
      if (exp_q1.size() == 0) note_error("rd_done on port 1 with no read outstanding");
      else check_ready("rd_data[1]", rd_data[1], exp_q1.pop_front());
    end
  end

  // ==========================================================================
  // stimulus tasks
  // ==========================================================================
  task automatic clear_inputs();
    cmd_stb = '0;
    rd_stb  = '0;
    for (int p = 0; p < `CVR_NWPORT; p++) cmd_op[p] = OP_NOP;
  endtask

  task automatic drive_cmd(int p, cvr_op_e op, checkpt_ndx_t chk, pregno_t preg);
    cmd_stb[p]  = 1'b1;
    cmd_op[p]   = op;
    cmd_chk[p]  = chk;
    cmd_preg[p] = preg;
  endtask

  // the expected bit is taken before this cycle's commands reach the model
  task automatic drive_read(int r, checkpt_ndx_t chk, pregno_t preg);
    rd_stb[r]  = 1'b1;
    rd_chk[r]  = chk;
    rd_preg[r] = preg;
    if (r == 0) exp_q0.push_back(ref_ready(chk, preg));
    else exp_q1.push_back(ref_ready(chk, preg));
  endtask

  // one clock cycle with inputs moving 1 ns after the edge
  task automatic step();
    apply_model();
    @(posedge clka);
    #1;
    clear_inputs();
  endtask

  task automatic wait_reads();
    int n;
    n = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && n < READ_TIMEOUT) begin
      @(posedge clka);
      #1;
      n++;
    end
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      note_error("rd_done never arrived for an outstanding read");
      exp_q0.delete();
      exp_q1.delete();
    end
  endtask

  // reads every bit of the table, two columns per cycle
  task automatic sweep_all();
    for (int p = 0; p < `CVR_NPREGS; p++) begin
      for (int c = 0; c < `CVR_NCHECK; c += 2) begin
        drive_read(0, checkpt_ndx_t'(c), pregno_t'(p));
        drive_read(1, checkpt_ndx_t'(c + 1), pregno_t'(p));
        step();
      end
    end
    wait_reads();
  endtask

  task automatic run_copy(checkpt_ndx_t dst, checkpt_ndx_t src);
    int           cnt;
    checkpt_ndx_t p1_chk;
    pregno_t      p1_preg;
    p1_chk  = other_chk(dst);
    p1_preg = rand_preg();
    drive_cmd(0, OP_COPY, dst, rand_preg());
    copy_src = src;
    // port 1 would flip a bit outside the copy if decode let it through
    drive_cmd(1, ref_ready(p1_chk, p1_preg) ? OP_CLR : OP_SET, p1_chk, p1_preg);
    drive_read(0, dst, rand_preg());                // still sees the column before the copy
    step();
    cnt = 0;
    while (busy && cnt < COPY_TIMEOUT) begin
      cnt++;
      check_flag("copy_done", copy_done, cnt == `CVR_NPREGS);
      drive_read(0, other_chk(dst), rand_preg());   // columns outside the copy stay valid
      drive_read(1, other_chk(dst), rand_preg());
      step();
    end
    if (busy) note_error("busy did not fall after a copy");
    check_count("busy cycles", cnt, `CVR_NPREGS);
    check_flag("copy_done", copy_done, 1'b0);
    wait_reads();
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial begin
    pregno_t      p0;
    pregno_t      p1;
    checkpt_ndx_t c0;
    checkpt_ndx_t c1;
    cvr_op_e      o0;
    cvr_op_e      o1;
    void'($urandom(23110));
    rst      = 1'b1;
    cmd_chk  = '0;
    cmd_preg = '0;
    copy_src = '0;
    rd_chk   = '0;
    rd_preg  = '0;
    clear_inputs();
    for (int i = 0; i < `CVR_NPREGS; i++) model[i] = '1;  // everything ready out of reset
    repeat (10) @(posedge clka);
    #1;
    rst = 1'b0;
    check_flag("busy", busy, 1'b0);
    check_flag("copy_done", copy_done, 1'b0);
    sweep_all();
    // single commands, each read in its own cycle and again afterwards
    for (int i = 0; i < 48; i++) begin
      p0 = rand_preg();
      c0 = rand_chk();
      drive_cmd(int'($urandom_range(0, 1)), rand_setclr(), c0, p0);
      drive_read(0, c0, p0);  // same cycle as the write so the old bit comes back
      step();
      drive_read(0, c0, p0);
      drive_read(1, rand_chk(), p0);
      step();
      wait_reads();
    end
    // both ports at once in every merge case
    for (int i = 0; i < 36; i++) begin
      p0 = rand_preg();
      c0 = rand_chk();
      o0 = rand_setclr();
      p1 = (i % 3 == 2) ? other_preg(p0) : p0;
      c1 = (i % 3 == 1) ? other_chk(c0) : c0;
      o1 = rand_setclr();
      if (i % 3 == 0) o1 = (o0 == OP_SET) ? OP_CLR : OP_SET;  // port 1 must win this bit
      drive_cmd(0, o0, c0, p0);
      drive_cmd(1, o1, c1, p1);
      step();
      drive_read(0, c0, p0);
      drive_read(1, c1, p1);
      step();
      wait_reads();
    end
    run_copy(2'd2, 2'd1);
    sweep_all();
    run_copy(2'd0, 2'd3);
    sweep_all();
    // long random mix on a narrow register range so ports collide often
    for (int i = 0; i < 400; i++) begin
      if ($urandom_range(0, 49) == 0) begin
        run_copy(rand_chk(), rand_chk());
      end else begin
        if ($urandom_range(0, 1) == 1) drive_cmd(0, pick_op(1'b0), rand_chk(), narrow_preg());
        if ($urandom_range(0, 1) == 1) drive_cmd(1, pick_op(1'b1), rand_chk(), narrow_preg());
        if ($urandom_range(0, 1) == 1) drive_read(0, rand_chk(), narrow_preg());
        if ($urandom_range(0, 1) == 1) drive_read(1, rand_chk(), narrow_preg());
        step();
      end
    end
    wait_reads();
    sweep_all();
    $display("reads compared: %0d, mismatches: %0d, other errors: %0d",
             reads_done, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* hdl/cvr_bank_execute.sv */
// ==========================================================================
// storage and write engine of the register-ready table
// holds one flop bank per command port plus the live value table that
// records which bank has the current word, and runs the column copy
// read taps go out to the result stage as raw bank words and LVT bits
// ==========================================================================

`include "cvr_config.svh"

module cvr_bank_execute
  import cvr_pkg::*;
(
  input  logic                              clka,
  input  logic                              rst,
  input  logic         [`CVR_NWPORT-1:0]    wen,
  input  pregno_t      [`CVR_NWPORT-1:0]    waddr,
  input  checkpt_ndx_t [`CVR_NWPORT-1:0]    wbit,
  input  logic         [`CVR_NWPORT-1:0]    wval,
  input  checkpt_ndx_t                      mbit,
  input  logic                              mval,
  input  logic                              men,
  input  logic                              copy_start,
  input  checkpt_ndx_t                      copy_dst,
  input  checkpt_ndx_t                      copy_src_q,
  input  pregno_t      [`CVR_NRPORT-1:0]    rd_preg,
  output chk_word_t    [`CVR_NRPORT-1:0]    bank0_word,
  output chk_word_t    [`CVR_NRPORT-1:0]    bank1_word,
  output logic         [`CVR_NRPORT-1:0]    lvt_sel,
  output logic                              busy,
  output logic                              copy_done
);

  localparam pregno_t LAST_PREG = pregno_t'(`CVR_NPREGS - 1);

  chk_word_t              bank [0:`CVR_NWPORT-1][0:`CVR_NPREGS-1];  // one bank per port
  logic [`CVR_NPREGS-1:0] lvt;                                       // bank holding the live word
  copy_state_e            cp_state;
  pregno_t                cp_cnt;                                    // register under copy
  chk_word_t              cur_word [0:`CVR_NWPORT-1];
  chk_word_t              new_word [0:`CVR_NWPORT-1];
  chk_word_t              cp_live;
  chk_word_t              cp_word;

  // ==========================================================================
  // write data
  // ==========================================================================
  // a write changes one bit, so the other bits must come from whichever bank
  // the LVT says is current for that register
  always_comb begin
    for (int b = 0; b < `CVR_NWPORT; b++) begin
      cur_word[b]          = bank[lvt[waddr[b]]][waddr[b]];
      new_word[b]          = cur_word[b];
      new_word[b][wbit[b]] = wval[b];
    end
    // merged command rides on bank 0 and is applied last so port 1 wins
    if (men) begin
      new_word[0][mbit] = mval;
    end
  end

  // copy word for the register the engine is on this cycle
  always_comb begin
    cp_live           = bank[lvt[cp_cnt]][cp_cnt];
    cp_word           = cp_live;
    cp_word[copy_dst] = cp_live[copy_src_q];  // every other column passes through unchanged
  end

  // ==========================================================================
  // copy engine
  // ==========================================================================
  always_ff @(posedge clka) begin
    if (rst) begin
      cp_state <= CP_IDLE;
      cp_cnt   <= '0;
    end else begin
      case (cp_state)
        CP_IDLE: begin
          if (copy_start) begin
            cp_state <= CP_RUN;
            cp_cnt   <= '0;  // walk starts at register 0
          end
        end
        CP_RUN: begin
          cp_cnt <= cp_cnt + 1'b1;
          if (cp_cnt == LAST_PREG) begin
            cp_state <= CP_IDLE;  // last register written this cycle
          end
        end
        default: cp_state <= CP_IDLE;
      endcase
    end
  end

  assign busy      = (cp_state == CP_RUN);
  assign copy_done = busy & (cp_cnt == LAST_PREG);  // high in the final busy cycle only

  // ==========================================================================
  // bank and LVT update
  // ==========================================================================
  // reset marks every register ready in every checkpoint through bank 0
  // bank 1 is never selected until a write points the LVT at it
  always_ff @(posedge clka) begin
    if (rst) begin
      for (int i = 0; i < `CVR_NPREGS; i++) begin
        bank[0][i] <= '1;
      end
      lvt <= '0;
    end else begin
      // decode holds off all writes while the copy runs so the two never collide
      if (busy) begin
        bank[0][cp_cnt] <= cp_word;
        lvt[cp_cnt]     <= 1'b0;
      end
      for (int b = 0; b < `CVR_NWPORT; b++) begin
        if (wen[b]) begin
          bank[b][waddr[b]] <= new_word[b];
          lvt[waddr[b]]     <= 1'(b);  // this bank now has the live copy
        end
      end
    end
  end

  // ==========================================================================
  // read taps
  // ==========================================================================
  // asynchronous reads of both banks, the result stage does the selection
  always_comb begin
    for (int r = 0; r < `CVR_NRPORT; r++) begin
      bank0_word[r] = bank[0][rd_preg[r]];
      bank1_word[r] = bank[1][rd_preg[r]];
      lvt_sel[r]    = lvt[rd_preg[r]];
    end
  end

endmodule

/* hdl/cvr_cmd_decode.sv */
// ==========================================================================
// command decode for the register-ready table
// maps the two command ports onto the two write banks, folds a same
// register pair into one bank 0 write and launches column copies
// ==========================================================================

`include "cvr_config.svh"

module cvr_cmd_decode
  import cvr_pkg::*;
(
  input  logic                              clka,
  input  logic                              rst,
  input  logic                              busy,        // copy engine running
  input  logic         [`CVR_NWPORT-1:0]    cmd_stb,
  input  cvr_op_e      [`CVR_NWPORT-1:0]    cmd_op,
  input  checkpt_ndx_t [`CVR_NWPORT-1:0]    cmd_chk,
  input  pregno_t      [`CVR_NWPORT-1:0]    cmd_preg,
  input  checkpt_ndx_t                      copy_src,    // source column for OP_COPY
  output logic         [`CVR_NWPORT-1:0]    wen,         // one write request per bank
  output pregno_t      [`CVR_NWPORT-1:0]    waddr,
  output checkpt_ndx_t [`CVR_NWPORT-1:0]    wbit,
  output logic         [`CVR_NWPORT-1:0]    wval,
  output checkpt_ndx_t                      mbit,        // second bit change on bank 0
  output logic                              mval,
  output logic                              men,
  output logic                              copy_start,
  output checkpt_ndx_t                      copy_dst,
  output checkpt_ndx_t                      copy_src_q
);

  logic [`CVR_NWPORT-1:0] live;      // strobe accepted this cycle
  logic [`CVR_NWPORT-1:0] bitop;     // accepted set or clear
  logic [`CVR_NWPORT-1:0] val;       // bit value the command writes
  logic                   p1_ok;     // port 1 survives a copy on port 0
  logic                   same_reg;  // both ports hit one register

  // strobes are dropped while the copy engine owns the banks
  always_comb begin
    for (int p = 0; p < `CVR_NWPORT; p++) begin
      live[p]  = cmd_stb[p] & ~busy;
      bitop[p] = live[p] & ((cmd_op[p] == OP_SET) | (cmd_op[p] == OP_CLR));
      val[p]   = (cmd_op[p] == OP_SET);
    end
  end

  assign copy_start = live[0] & (cmd_op[0] == OP_COPY);  // OP_COPY on port 1 never matches here
  assign p1_ok      = bitop[1] & ~copy_start;            // port 1 is discarded in a copy cycle
  assign same_reg   = bitop[0] & p1_ok & (cmd_preg[0] == cmd_preg[1]);

  // ==========================================================================
  // bank requests
  // ==========================================================================
  // each port normally owns its bank, but a shared register must land in one
  // bank or the LVT could only point at one of the two halves
  always_comb begin
    wen[0]   = bitop[0];
    waddr[0] = cmd_preg[0];
    wbit[0]  = cmd_chk[0];
    wval[0]  = val[0];
    wen[1]   = p1_ok & ~same_reg;  // folded into bank 0 when the registers match
    waddr[1] = cmd_preg[1];
    wbit[1]  = cmd_chk[1];
    wval[1]  = val[1];
    // port 1 change is applied after port 0 so it wins on a shared bit
    men      = same_reg;
    mbit     = cmd_chk[1];
    mval     = val[1];
  end

  // copy columns are held for the whole run of the engine
  always_ff @(posedge clka) begin
    if (rst) begin
      copy_dst   <= '0;
      copy_src_q <= '0;
    end else if (copy_start) begin
      copy_dst   <= cmd_chk[0];  // destination column comes in on the checkpoint field
      copy_src_q <= copy_src;
    end
  end

endmodule

/* hdl/cvr_config.svh */
// ==========================================================================
// sizing for the checkpointed register-ready table
// include this in every design and testbench file that needs a table size
// the package builds its index and word types from these numbers
// ==========================================================================

`ifndef CVR_CONFIG_SVH
`define CVR_CONFIG_SVH

// number of physical registers, one ready word is kept for each
`define CVR_NPREGS 64

// number of branch checkpoints, which is also the width of a ready word
`define CVR_NCHECK 4

// command ports from allocation and writeback
// decode and execute are written for exactly two of these
`define CVR_NWPORT 2

// read ports into the table
`define CVR_NRPORT 2

`endif

/* hdl/cvr_pkg.sv */
// ==========================================================================
// shared types for the checkpointed register-ready table
// import by wildcard in any module header that uses them
// ==========================================================================

`include "cvr_config.svh"

package cvr_pkg;

  // physical register number, wide enough to address every register
  typedef logic [$clog2(`CVR_NPREGS)-1:0] pregno_t;

  // index of one checkpoint column
  typedef logic [$clog2(`CVR_NCHECK)-1:0] checkpt_ndx_t;

  // ready bits of one register across all checkpoints
  typedef logic [`CVR_NCHECK-1:0] chk_word_t;

  // ==========================================================================
  // command opcodes as they arrive on a command port
  // ==========================================================================
  typedef enum logic [1:0] {
    OP_NOP  = 2'd0,  // nothing to do this cycle
    OP_SET  = 2'd1,  // result written back so the bit goes to 1
    OP_CLR  = 2'd2,  // register allocated so the bit goes to 0
    OP_COPY = 2'd3   // whole column copy, only honoured on port 0
  } cvr_op_e;

  // ==========================================================================
  // copy engine state
  // ==========================================================================
  typedef enum logic {
    CP_IDLE = 1'b0,  // no copy in progress
    CP_RUN  = 1'b1   // walking the registers one per cycle
  } copy_state_e;

endpackage

/* hdl/cvr_read_result.sv */
// ==========================================================================
// read result stage of the register-ready table
// picks the live bank word through the LVT in the request cycle and
// returns the chosen checkpoint bit with a done strobe one cycle later
// ==========================================================================

`include "cvr_config.svh"

module cvr_read_result
  import cvr_pkg::*;
(
  input  logic                              clka,
  input  logic                              rst,
  input  logic         [`CVR_NRPORT-1:0]    rd_stb,
  input  checkpt_ndx_t [`CVR_NRPORT-1:0]    rd_chk,
  input  chk_word_t    [`CVR_NRPORT-1:0]    bank0_word,
  input  chk_word_t    [`CVR_NRPORT-1:0]    bank1_word,
  input  logic         [`CVR_NRPORT-1:0]    lvt_sel,
  output logic         [`CVR_NRPORT-1:0]    rd_done,
  output logic         [`CVR_NRPORT-1:0]    rd_data
);

  chk_word_t sel_word [0:`CVR_NRPORT-1];  // live word per read port

  // same cycle select so a write at this edge is not seen by this read
  always_comb begin
    for (int r = 0; r < `CVR_NRPORT; r++) begin
      sel_word[r] = lvt_sel[r] ? bank1_word[r] : bank0_word[r];
    end
  end

  // ==========================================================================
  // output registers
  // ==========================================================================
  always_ff @(posedge clka) begin
    if (rst) begin
      rd_done <= '0;
    end else begin
      rd_done <= rd_stb;  // one cycle pulse per request
    end
  end

  // data is only meaningful alongside rd_done and simply holds otherwise
  always_ff @(posedge clka) begin
    for (int r = 0; r < `CVR_NRPORT; r++) begin
      if (rd_stb[r]) begin
        rd_data[r] <= sel_word[r][rd_chk[r]];
      end
    end
  end

endmodule

/* hdl/cvr_top.sv */
// ==========================================================================
// checkpointed register-ready table for the rename stage
// two command ports set, clear or copy ready bits per checkpoint and two
// read ports return one bit each a cycle after the request
// keep command strobes low while busy is high
// ==========================================================================

`include "cvr_config.svh"

module cvr_top
  import cvr_pkg::*;
(
  input  logic                              clka,
  input  logic                              rst,
  input  logic         [`CVR_NWPORT-1:0]    cmd_stb,
  input  cvr_op_e      [`CVR_NWPORT-1:0]    cmd_op,
  input  checkpt_ndx_t [`CVR_NWPORT-1:0]    cmd_chk,
  input  pregno_t      [`CVR_NWPORT-1:0]    cmd_preg,
  input  checkpt_ndx_t                      copy_src,   // column copied from on OP_COPY
  input  logic         [`CVR_NRPORT-1:0]    rd_stb,
  input  checkpt_ndx_t [`CVR_NRPORT-1:0]    rd_chk,
  input  pregno_t      [`CVR_NRPORT-1:0]    rd_preg,
  output logic         [`CVR_NRPORT-1:0]    rd_done,
  output logic         [`CVR_NRPORT-1:0]    rd_data,
  output logic                              busy,
  output logic                              copy_done
);

  // decode to execute
  logic         [`CVR_NWPORT-1:0] wen;
  pregno_t      [`CVR_NWPORT-1:0] waddr;
  checkpt_ndx_t [`CVR_NWPORT-1:0] wbit;
  logic         [`CVR_NWPORT-1:0] wval;
  checkpt_ndx_t                   mbit;
  logic                           mval;
  logic                           men;
  logic                           copy_start;
  checkpt_ndx_t                   copy_dst;
  checkpt_ndx_t                   copy_src_q;

  // execute to result
  chk_word_t    [`CVR_NRPORT-1:0] bank0_word;
  chk_word_t    [`CVR_NRPORT-1:0] bank1_word;
  logic         [`CVR_NRPORT-1:0] lvt_sel;

  // ==========================================================================
  // decode, execute and result
  // ==========================================================================
  cvr_cmd_decode u_decode (
    .clka       (clka),
    .rst        (rst),
    .busy       (busy),       // fed back from the copy engine
    .cmd_stb    (cmd_stb),
    .cmd_op     (cmd_op),
    .cmd_chk    (cmd_chk),
    .cmd_preg   (cmd_preg),
    .copy_src   (copy_src),
    .wen        (wen),
    .waddr      (waddr),
    .wbit       (wbit),
    .wval       (wval),
    .mbit       (mbit),
    .mval       (mval),
    .men        (men),
    .copy_start (copy_start),
    .copy_dst   (copy_dst),
    .copy_src_q (copy_src_q)
  );

  cvr_bank_execute u_execute (
    .clka       (clka),
    .rst        (rst),
    .wen        (wen),
    .waddr      (waddr),
    .wbit       (wbit),
    .wval       (wval),
    .mbit       (mbit),
    .mval       (mval),
    .men        (men),
    .copy_start (copy_start),
    .copy_dst   (copy_dst),
    .copy_src_q (copy_src_q),
    .rd_preg    (rd_preg),    // read addresses go straight to the banks
    .bank0_word (bank0_word),
    .bank1_word (bank1_word),
    .lvt_sel    (lvt_sel),
    .busy       (busy),
    .copy_done  (copy_done)
  );

  cvr_read_result u_result (
    .clka       (clka),
    .rst        (rst),
    .rd_stb     (rd_stb),
    .rd_chk     (rd_chk),
    .bank0_word (bank0_word),
    .bank1_word (bank1_word),
    .lvt_sel    (lvt_sel),
    .rd_done    (rd_done),
    .rd_data    (rd_data)
  );

endmodule

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/100ps --top-module cvr_tb \
  -f compile.f -o vcvr_tb \
  && ./obj_dir/vcvr_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
exit 0
